/* Makefile */
VERILATOR ?= verilator
VFLAGS = --binary --timing -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP = tb_output_controller
RTL_TOP = output_controller
FILE_LIST = src.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILE_LIST) *.sv *.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) -Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "Testbench passed" $(LOG); then echo "Simulation ok"; \
	else echo "Simulation not ok"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* frame_streamer.sv */
// Writes FRAME_PIXELS words from SDRAM_BASE in steps of 4; pixels at or above BUFFER_PIXELS go out black
`timescale 1ns/1ns
`default_nettype none

`include "output_controller_config.svh"

module frame_streamer
(
	input logic clk,
	input logic reset,
	input logic frame_start,
	output logic stream_busy,
	output logic stream_read_enable,
	output logic [`FRAME_INDEX_WIDTH-1:0] stream_index,
	input output_controller_pkg::pixel_t stream_pixel,
	output logic sdram_write,
	output output_controller_pkg::sdram_write_t sdram_beat,
	input logic waitrequest,
	output logic finished
);
	import output_controller_pkg::*;

	localparam frame_index_t last_index = frame_index_t'(`FRAME_PIXELS - 1);
	localparam frame_index_t buffer_limit = frame_index_t'(`BUFFER_PIXELS);
	localparam int pad_width = `SDRAM_ADDR_WIDTH - `FRAME_INDEX_WIDTH - 2;

	stream_state_e state;
	stream_state_e next_state;
	frame_index_t pixel_index;
	frame_index_t next_index;
	logic in_buffer;
	logic [`SDRAM_ADDR_WIDTH-1:0] byte_offset;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= stream_idle;
			pixel_index <= '0;
		end
		else
		begin
			state <= next_state;
			pixel_index <= next_index;
		end
	end

	always_comb
	begin
		next_state = state;
		next_index = pixel_index;
		case (state)
			stream_idle, stream_done:
			begin
				// A new frame restarts from pixel 0
				if (frame_start)
				begin
					next_state = stream_fetch;
					next_index = '0;
				end
			end
			stream_fetch:
			begin
				next_state = stream_send;
			end
			stream_send:
			begin
				// Hold the beat until the slave drops waitrequest
				if (!waitrequest)
				begin
					if (pixel_index == last_index)
					begin
						next_state = stream_done;
					end
					else
					begin
						next_state = stream_fetch;
						next_index = pixel_index + 1'b1;
					end
				end
			end
			default:
			begin
				next_state = stream_idle;
			end
		endcase
	end

	assign stream_busy = (state == stream_fetch) || (state == stream_send);
	assign stream_read_enable = (state == stream_fetch);
	assign stream_index = pixel_index;
	assign sdram_write = (state == stream_send);
	assign finished = (state == stream_done);

	assign in_buffer = (pixel_index < buffer_limit);
	assign byte_offset = {{pad_width{1'b0}}, pixel_index, 2'b00};

	// Byte 0 zero, then red, green, blue
	always_comb
	begin
		sdram_beat.address = `SDRAM_BASE + byte_offset;
		if (in_buffer)
		begin
			sdram_beat.data = {stream_pixel.blue, stream_pixel.green, stream_pixel.red, 8'h00};
		end
		else
		begin
			sdram_beat.data = '0;
		end
	end

endmodule

`default_nettype wire

/* output_controller.sv */
// Host ports are ready only while no frame streams; frame_start is ignored mid-frame
`timescale 1ns/1ns
`default_nettype none

`include "output_controller_config.svh"

module output_controller
(
	input logic clk,
	input logic reset,
	input logic write_valid,
	output logic write_ready,
	input output_controller_pkg::pixel_write_t write_request,
	input logic read_valid,
	output logic read_ready,
	input logic [`FRAME_INDEX_WIDTH-1:0] read_index,
	output output_controller_pkg::pixel_t read_pixel,
	output logic read_pixel_valid,
	input logic frame_start,
	output logic sdram_write,
	output output_controller_pkg::sdram_write_t sdram_beat,
	input logic waitrequest,
	output logic finished
);
	import output_controller_pkg::*;

	logic stream_busy;
	logic stream_read_enable;
	logic [`FRAME_INDEX_WIDTH-1:0] stream_index;
	pixel_t stream_pixel;

	pixel_buffer pixel_buffer_inst
	(
		.clk(clk),
		.reset(reset),
		.stream_busy(stream_busy),
		.write_valid(write_valid),
		.write_ready(write_ready),
		.write_request(write_request),
		.read_valid(read_valid),
		.read_ready(read_ready),
		.read_index(read_index),
		.read_pixel(read_pixel),
		.read_pixel_valid(read_pixel_valid),
		.stream_read_enable(stream_read_enable),
		.stream_index(stream_index),
		.stream_pixel(stream_pixel)
	);

	frame_streamer frame_streamer_inst
	(
		.clk(clk),
		.reset(reset),
		.frame_start(frame_start),
		.stream_busy(stream_busy),
		.stream_read_enable(stream_read_enable),
		.stream_index(stream_index),
		.stream_pixel(stream_pixel),
		.sdram_write(sdram_write),
		.sdram_beat(sdram_beat),
		.waitrequest(waitrequest),
		.finished(finished)
	);

endmodule

`default_nettype wire

/* output_controller_config.svh */
// BUFFER_PIXELS must not exceed FRAME_PIXELS, and FRAME_INDEX_WIDTH must cover the whole frame
`ifndef OUTPUT_CONTROLLER_CONFIG_SVH
`define OUTPUT_CONTROLLER_CONFIG_SVH

// Frame geometry in pixels
`define FRAME_WIDTH 32
`define FRAME_HEIGHT 24
`define FRAME_PIXELS (`FRAME_WIDTH * `FRAME_HEIGHT)

// On-chip storage covers the first part of the frame only
`define BUFFER_PIXELS 256

`define FRAME_INDEX_WIDTH 10

// Byte address of pixel 0 with one 32-bit word per pixel
`define SDRAM_ADDR_WIDTH 28
`define SDRAM_BASE 28'h8000000

`endif

/* output_controller_pkg.sv */
// Shared types for the output stage; widths come from output_controller_config.svh
`default_nettype none

`include "output_controller_config.svh"

package output_controller_pkg;

	typedef logic [`FRAME_INDEX_WIDTH-1:0] frame_index_t;

	// One RGB pixel
	typedef struct packed
	{
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} pixel_t;

	// Host write request
	typedef struct packed
	{
		frame_index_t index;
		pixel_t pixel;
	} pixel_write_t;

	// One beat to the SDRAM write master
	typedef struct packed
	{
		logic [`SDRAM_ADDR_WIDTH-1:0] address;
		logic [31:0] data;
	} sdram_write_t;

	typedef enum logic [1:0]
	{
		stream_idle,
		stream_fetch,
		stream_send,
		stream_done
	} stream_state_e;

endpackage

`default_nettype wire

/* pixel_buffer.sv */
// Host ports stall during a frame; indices at or above BUFFER_PIXELS write nothing and read black
`timescale 1ns/1ns
`default_nettype none

`include "output_controller_config.svh"

module pixel_buffer
(
	input logic clk,
	input logic reset,
	input logic stream_busy,
	input logic write_valid,
	output logic write_ready,
	input output_controller_pkg::pixel_write_t write_request,
	input logic read_valid,
	output logic read_ready,
	input logic [`FRAME_INDEX_WIDTH-1:0] read_index,
	output output_controller_pkg::pixel_t read_pixel,
	output logic read_pixel_valid,
	input logic stream_read_enable,
	input logic [`FRAME_INDEX_WIDTH-1:0] stream_index,
	output output_controller_pkg::pixel_t stream_pixel
);
	import output_controller_pkg::*;

	localparam int addr_width = $clog2(`BUFFER_PIXELS);
	localparam frame_index_t buffer_limit = frame_index_t'(`BUFFER_PIXELS);

	pixel_t memory [`BUFFER_PIXELS];
	logic write_fire;
	logic read_fire;
	logic port_enable;
	frame_index_t port_index;
	pixel_t port_pixel;
	pixel_t held_pixel;

	assign write_ready = !stream_busy;
	assign read_ready = !stream_busy;
	assign write_fire = write_valid && write_ready;
	assign read_fire = read_valid && read_ready;

	// Streamer owns the read port for the whole frame
	assign port_index = stream_busy ? stream_index : read_index;
	assign port_enable = stream_busy ? stream_read_enable : read_fire;

	always_ff @(posedge clk)
	begin
		if (write_fire && (write_request.index < buffer_limit))
		begin
			memory[write_request.index[addr_width-1:0]] <= write_request.pixel;
		end
	end

	always_ff @(posedge clk)
	begin
		if (port_enable)
		begin
			if (port_index < buffer_limit)
			begin
				port_pixel <= memory[port_index[addr_width-1:0]];
			end
			else
			begin
				port_pixel <= '0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			read_pixel_valid <= 1'b0;
		end
		else
		begin
			read_pixel_valid <= read_fire;
		end
	end

	// Keep the host result once the streamer reuses the port
	always_ff @(posedge clk)
	begin
		if (read_pixel_valid)
		begin
			held_pixel <= port_pixel;
		end
	end

	assign read_pixel = read_pixel_valid ? port_pixel : held_pixel;
	assign stream_pixel = port_pixel;

endmodule

`default_nettype wire

/* src.f */
+incdir+.
output_controller_pkg.sv
pixel_buffer.sv
frame_streamer.sv
output_controller.sv
tb_output_controller.sv

/* tb_output_controller.sv */
// Assumes the default geometry in output_controller_config.svh; the SDRAM model stalls at random
`timescale 1ns/1ns
`default_nettype none

`include "output_controller_config.svh"

module tb_output_controller;
	import output_controller_pkg::*;

	localparam int table_size = 6;
	localparam int frame_timeout = 20 * `FRAME_PIXELS;
	localparam int port_timeout = 100;

	logic clk;
	logic reset;
	logic write_valid;
	logic write_ready;
	pixel_write_t write_request;
	logic read_valid;
	logic read_ready;
	frame_index_t read_index;
	pixel_t read_pixel;
	logic read_pixel_valid;
	logic frame_start;
	logic sdram_write;
	sdram_write_t sdram_beat;
	logic waitrequest;
	logic finished;

	pixel_write_t stimulus [table_size];
	pixel_t expected_pixel [`FRAME_PIXELS];
	sdram_write_t accepted_beats [$];
	int errors;
	int checks;

	output_controller output_controller_inst
	(
		.clk(clk),
		.reset(reset),
		.write_valid(write_valid),
		.write_ready(write_ready),
		.write_request(write_request),
		.read_valid(read_valid),
		.read_ready(read_ready),
		.read_index(read_index),
		.read_pixel(read_pixel),
		.read_pixel_valid(read_pixel_valid),
		.frame_start(frame_start),
		.sdram_write(sdram_write),
		.sdram_beat(sdram_beat),
		.waitrequest(waitrequest),
		.finished(finished)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// SDRAM slave that stalls about one cycle in four
	initial
	begin
		void'($urandom(57));
		waitrequest = 1'b0;
		forever
		begin
			@(negedge clk);
			waitrequest = (($urandom % 4) == 0);
			// Beat is taken on the coming rising edge
			if (sdram_write && !waitrequest)
			begin
				accepted_beats.push_back(sdram_beat);
			end
		end
	end

	// Byte 0 zero, byte 1 red, byte 2 green, byte 3 blue
	function automatic logic [31:0] pack_word(input pixel_t pixel);
		logic [31:0] word;
		word[7:0] = 8'h00;
		word[15:8] = pixel.red;
		word[23:16] = pixel.green;
		word[31:24] = pixel.blue;
		return word;
	endfunction

	function automatic pixel_t index_colour(input frame_index_t index);
		pixel_t colour;
		colour.red = index[7:0];
		colour.green = 8'(index >> 2) ^ 8'ha5;
		colour.blue = 8'(index * 3);
		return colour;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual === expected)
		else
		begin
			errors++;
			$display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		check_value(name, {31'b0, expected}, {31'b0, actual});
	endtask

	task automatic abort_on_timeout(input string what);
		errors++;
		$display("Timeout at %0t ns while waiting for %s", $time, what);
		$display("%0d errors in %0d checks", errors, checks);
		$display("Testbench failed");
		$finish;
	endtask

	task automatic write_pixel(input frame_index_t index, input pixel_t pixel);
		int cycles;
		cycles = 0;
		@(negedge clk);
		write_valid = 1'b1;
		write_request.index = index;
		write_request.pixel = pixel;
		while (!write_ready)
		begin
			if (cycles == port_timeout)
			begin
				abort_on_timeout("write_ready");
			end
			@(negedge clk);
			cycles++;
		end
		@(negedge clk);
		write_valid = 1'b0;
		// Only buffered pixels are kept
		if (32'(index) < `BUFFER_PIXELS)
		begin
			expected_pixel[index] = pixel;
		end
	endtask

	task automatic read_check(input frame_index_t index);
		int cycles;
		cycles = 0;
		@(negedge clk);
		read_valid = 1'b1;
		read_index = index;
		while (!read_ready)
		begin
			if (cycles == port_timeout)
			begin
				abort_on_timeout("read_ready");
			end
			@(negedge clk);
			cycles++;
		end
		@(negedge clk);
		read_valid = 1'b0;
		cycles = 0;
		while (!read_pixel_valid)
		begin
			if (cycles == port_timeout)
			begin
				abort_on_timeout("read_pixel_valid");
			end
			@(negedge clk);
			cycles++;
		end
		check_value("read_pixel", 32'(expected_pixel[index]), 32'(read_pixel));
		// Response lasts one cycle
		@(negedge clk);
		check_flag("read_pixel_valid", 1'b0, read_pixel_valid);
	endtask

	task automatic run_frame();
		int cycles;
		cycles = 0;
		accepted_beats.delete();
		@(negedge clk);
		frame_start = 1'b1;
		@(negedge clk);
		frame_start = 1'b0;
		check_flag("finished", 1'b0, finished);
		while (!finished)
		begin
			// Host ports stay stalled for the whole frame
			check_flag("write_ready", 1'b0, write_ready);
			check_flag("read_ready", 1'b0, read_ready);
			if (cycles == frame_timeout)
			begin
				abort_on_timeout("finished");
			end
			@(negedge clk);
			cycles++;
		end
		check_value("beat count", `FRAME_PIXELS, accepted_beats.size());
		for (int i = 0; i < accepted_beats.size() && i < `FRAME_PIXELS; i++)
		begin
			check_value("sdram_beat.address", `SDRAM_BASE + 4 * i,
				32'(accepted_beats[i].address));
			check_value("sdram_beat.data", pack_word(expected_pixel[i]), accepted_beats[i].data);
			if (i >= `BUFFER_PIXELS)
			begin
				check_value("blank sdram_beat.data", 0, accepted_beats[i].data);
			end
		end
		repeat (4)
		begin
			@(negedge clk);
			check_flag("sdram_write", 1'b0, sdram_write);
			check_flag("finished", 1'b1, finished);
		end
	endtask

	initial
	begin
		errors = 0;
		checks = 0;
		reset = 1'b1;
		write_valid = 1'b0;
		write_request = '0;
		read_valid = 1'b0;
		read_index = '0;
		frame_start = 1'b0;
		for (int i = 0; i < `FRAME_PIXELS; i++)
		begin
			expected_pixel[i] = '0;
		end
		stimulus[0] = {frame_index_t'(0), 24'hff0000};
		stimulus[1] = {frame_index_t'(1), 24'h00ff00};
		stimulus[2] = {frame_index_t'(2), 24'h0000ff};
		stimulus[3] = {frame_index_t'(3), 24'hffffff};
		stimulus[4] = {frame_index_t'(`BUFFER_PIXELS - 1), 24'h123456};
		stimulus[5] = {frame_index_t'(`BUFFER_PIXELS), 24'habcdef};

		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_flag("sdram_write", 1'b0, sdram_write);
		check_flag("finished", 1'b0, finished);
		check_flag("write_ready", 1'b1, write_ready);
		check_flag("read_ready", 1'b1, read_ready);

		for (int k = 0; k < table_size; k++)
		begin
			write_pixel(stimulus[k].index, stimulus[k].pixel);
		end
		for (int i = 4; i < `BUFFER_PIXELS - 1; i++)
		begin
			write_pixel(frame_index_t'(i), index_colour(frame_index_t'(i)));
		end
		for (int k = 0; k < table_size; k++)
		begin
			read_check(stimulus[k].index);
		end
		run_frame();

		// New colours for part of the table
		for (int k = 0; k < table_size; k += 2)
		begin
			write_pixel(stimulus[k].index, ~stimulus[k].pixel);
		end
		read_check(stimulus[0].index);
		run_frame();
		// Last host result survives the streamer's use of the port
		check_value("held read_pixel", 32'(expected_pixel[stimulus[0].index]), 32'(read_pixel));

		$display("%0d errors in %0d checks", errors, checks);
		if (errors == 0)
		begin
			$display("Testbench passed");
		end
		else
		begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
